//--- logic/chip_pkg.sv
package chip_pkg;

  ////////////////////////////////////////
  // Configuration frames
  ////////////////////////////////////////

  localparam int tag_client_width_gp  = 2;
  localparam int tag_payload_width_gp = 8;

  // Start bit, client id, payload
  localparam int tag_frame_bits_gp = 1 + tag_client_width_gp + tag_payload_width_gp;

  localparam int tag_clk_gen_id_gp = 0;
  localparam int tag_core_id_gp    = 1;

  ////////////////////////////////////////
  // Link
  ////////////////////////////////////////

  localparam int link_width_gp   = 16;
  localparam int link_credits_gp = 4;

  // Divider toggles every ds+1 core cycles
  typedef struct packed {
    logic [1:0] reserved;
    logic [5:0] ds;
  } clk_gen_cfg_s;

  typedef struct packed {
    logic       link_enable;
    logic [6:0] offset;
  } core_cfg_s;

  // One client word, viewed by client id
  typedef union packed {
    clk_gen_cfg_s clk_gen;
    core_cfg_s    core;
  } tag_payload_u;

endpackage

//--- logic/core_link_if.sv
`timescale 1ns/10ps

interface core_link_if
  #(parameter int link_width_p = 16)
  ();

  // Receive side, FIFO head toward the core
  logic                    rx_v;
  logic [link_width_p-1:0] rx_data;
  logic                    rx_yumi;

  // Transmit side, core toward the output register
  logic                    tx_v;
  logic [link_width_p-1:0] tx_data;
  logic                    tx_ready;

  modport rx_mp
    (output rx_v
    ,output rx_data
    ,input  rx_yumi
    );

  modport tx_mp
    (input  tx_v
    ,input  tx_data
    ,output tx_ready
    );

  modport core_mp
    (input  rx_v
    ,input  rx_data
    ,output rx_yumi
    ,output tx_v
    ,output tx_data
    ,input  tx_ready
    );

endinterface

//--- logic/tag_master.sv
`timescale 1ns/10ps

module tag_master
  (input  logic                   core_clk_i
  ,input  logic                   rst_n_i
  ,input  logic                   tag_en_i
  ,input  logic                   tag_data_i
  ,output chip_pkg::tag_payload_u clk_gen_cfg_o
  ,output chip_pkg::tag_payload_u core_cfg_o
  );

  import chip_pkg::*;

  // Bits following the start bit
  localparam int body_bits_lp = tag_frame_bits_gp - 1;
  localparam int cnt_width_lp = $clog2(tag_frame_bits_gp);

  typedef enum logic {e_idle, e_shift} state_e;

  state_e                         state_r;
  logic [cnt_width_lp-1:0]        cnt_r;
  logic [body_bits_lp-2:0]        shift_r;
  logic [body_bits_lp-1:0]        frame;
  logic [tag_client_width_gp-1:0] frame_id;
  tag_payload_u                   frame_payload;
  logic                           frame_done;
  tag_payload_u                   clk_gen_cfg_r;
  tag_payload_u                   core_cfg_r;

  // Last bit joins the frame straight from the pin
  assign frame         = {shift_r, tag_data_i};
  assign frame_id      = frame[body_bits_lp-1 -: tag_client_width_gp];
  assign frame_payload = frame[tag_payload_width_gp-1:0];
  assign frame_done    = (state_r == e_shift) & tag_en_i
                       & (cnt_r == cnt_width_lp'(body_bits_lp - 1));

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else if (state_r == e_idle)
    begin
      if (tag_en_i & tag_data_i)
      begin
        state_r <= e_shift;
        cnt_r   <= '0;
      end
    end
    else if (!tag_en_i | frame_done)
      state_r <= e_idle;
    else
      cnt_r <= cnt_r + 1'b1;
  end

  always_ff @(posedge core_clk_i)
  begin
    if ((state_r == e_shift) & tag_en_i)
      shift_r <= frame[body_bits_lp-2:0];
  end

  // Ids without a client are dropped
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      clk_gen_cfg_r <= '0;
      core_cfg_r    <= '0;
    end
    else if (frame_done)
    begin
      if (frame_id == tag_client_width_gp'(tag_clk_gen_id_gp))
        clk_gen_cfg_r <= frame_payload;
      else if (frame_id == tag_client_width_gp'(tag_core_id_gp))
        core_cfg_r <= frame_payload;
    end
  end

  assign clk_gen_cfg_o = clk_gen_cfg_r;
  assign core_cfg_o    = core_cfg_r;

endmodule

//--- logic/clk_out_gen.sv
`timescale 1ns/10ps

module clk_out_gen
  (input  logic                   core_clk_i
  ,input  logic                   rst_n_i
  ,input  logic                   ext_clk_i
  ,input  logic                   out_disable_i
  ,input  logic [1:0]             sel_i
  ,input  chip_pkg::tag_payload_u cfg_i
  ,output logic                   clk_o
  );

  import chip_pkg::*;

  clk_gen_cfg_s cfg;

  localparam int ds_width_lp = $bits(cfg.ds);

  logic [ds_width_lp-1:0] ds_r;
  logic [ds_width_lp-1:0] cnt_r;
  logic                   div_clk_r;
  logic                   ds_change;
  logic                   clk_sel;

  assign cfg       = cfg_i.clk_gen;
  assign ds_change = (cfg.ds != ds_r);

  ////////////////////////////////////////
  // Divider
  ////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ds_r      <= '0;
      cnt_r     <= '0;
      div_clk_r <= 1'b0;
    end
    else
    begin
      ds_r <= cfg.ds;
      // New ds restarts the divided clock from low
      if (ds_change)
      begin
        cnt_r     <= '0;
        div_clk_r <= 1'b0;
      end
      else if (cnt_r == cfg.ds)
      begin
        cnt_r     <= '0;
        div_clk_r <= ~div_clk_r;
      end
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Output select
  ////////////////////////////////////////

  always_comb
  begin
    case (sel_i)
      2'd0:    clk_sel = core_clk_i;
      2'd1:    clk_sel = div_clk_r;
      2'd2:    clk_sel = ext_clk_i;
      default: clk_sel = 1'b0;
    endcase
  end

  assign clk_o = clk_sel & ~out_disable_i;

endmodule

//--- logic/link_rx.sv
`timescale 1ns/10ps

module link_rx
  #(parameter int link_width_p   = 16
   ,parameter int link_credits_p = 4
   )
  (input  logic                    core_clk_i
  ,input  logic                    rst_n_i
  ,input  logic                    link_v_i
  ,input  logic [link_width_p-1:0] link_data_i
  ,output logic                    link_tkn_o
  ,core_link_if.rx_mp              core_link
  );

  localparam int ptr_width_lp = (link_credits_p > 1) ? $clog2(link_credits_p) : 1;
  localparam int cnt_width_lp = $clog2(link_credits_p + 1);

  logic [link_width_p-1:0] mem_r [link_credits_p];
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    full;
  logic                    push;
  logic                    pop;

  assign full = (count_r == cnt_width_lp'(link_credits_p));
  assign push = link_v_i & ~full;
  assign pop  = core_link.rx_yumi;

  assign core_link.rx_v    = (count_r != '0);
  assign core_link.rx_data = mem_r[rptr_r];

  always_ff @(posedge core_clk_i)
  begin
    if (push)
      mem_r[wptr_r] <= link_data_i;
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
    end
    else
    begin
      if (push)
        wptr_r <= (wptr_r == ptr_width_lp'(link_credits_p - 1)) ? '0 : wptr_r + 1'b1;
      if (pop)
        rptr_r <= (rptr_r == ptr_width_lp'(link_credits_p - 1)) ? '0 : rptr_r + 1'b1;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      count_r <= '0;
    else
    begin
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // One token back to the sender per word popped
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      link_tkn_o <= 1'b0;
    else
      link_tkn_o <= pop;
  end

endmodule

//--- logic/link_tx.sv
`timescale 1ns/10ps

module link_tx
  #(parameter int link_width_p   = 16
   ,parameter int link_credits_p = 4
   )
  (input  logic                    core_clk_i
  ,input  logic                    rst_n_i
  ,input  logic                    link_tkn_i
  ,output logic                    link_v_o
  ,output logic [link_width_p-1:0] link_data_o
  ,core_link_if.tx_mp              core_link
  );

  localparam int cnt_width_lp = $clog2(link_credits_p + 1);

  logic [cnt_width_lp-1:0] credit_r;
  logic                    send;

  assign send               = core_link.tx_v;
  assign core_link.tx_ready = (credit_r != '0);

  ////////////////////////////////////////
  // Credits
  ////////////////////////////////////////

  // Far end starts with an empty FIFO
  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      credit_r <= cnt_width_lp'(link_credits_p);
    else
    begin
      case ({send, link_tkn_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
    end
  end

  ////////////////////////////////////////
  // Output word
  ////////////////////////////////////////

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      link_v_o <= 1'b0;
    else
      link_v_o <= send;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (send)
      link_data_o <= core_link.tx_data;
  end

endmodule

//--- logic/core_complex.sv
`timescale 1ns/10ps

module core_complex
  #(parameter int link_width_p = 16)
  (input  logic                   core_clk_i
  ,input  logic                   rst_n_i
  ,input  chip_pkg::tag_payload_u cfg_i
  ,core_link_if.core_mp           core_link
  );

  import chip_pkg::*;

  core_cfg_s cfg;

  localparam int offset_width_lp = $bits(cfg.offset);

  logic [link_width_p-1:0]    data_r;
  logic [offset_width_lp-1:0] offset_r;
  logic                       valid_r;
  logic                       send;
  logic                       pop;

  assign cfg = cfg_i.core;

  // Staged word leaves as soon as a credit is held
  assign send = valid_r & core_link.tx_ready;

  // Next word is popped while the current one is sent
  assign pop  = cfg.link_enable & core_link.rx_v & (~valid_r | send);

  assign core_link.rx_yumi = pop;
  assign core_link.tx_v    = send;
  assign core_link.tx_data = data_r + link_width_p'(offset_r);

  always_ff @(posedge core_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_r <= 1'b0;
    else if (pop)
      valid_r <= 1'b1;
    else if (send)
      valid_r <= 1'b0;
  end

  // Offset travels with its word
  always_ff @(posedge core_clk_i)
  begin
    if (pop)
    begin
      data_r   <= core_link.rx_data;
      offset_r <= cfg.offset;
    end
  end

endmodule

//--- logic/chip_top.sv
`timescale 1ns/10ps

module chip_top
  (input  logic        core_clk_i
  ,input  logic        rst_n_i
  ,input  logic        tag_en_i
  ,input  logic        tag_data_i
  ,input  logic        ext_clk_i
  ,input  logic        out_disable_i
  ,input  logic [1:0]  sel_i
  ,input  logic        link_v_i
  ,input  logic        link_tkn_i
  ,input  logic [15:0] link_data_i
  ,output logic        clk_o
  ,output logic        link_v_o
  ,output logic        link_tkn_o
  ,output logic [15:0] link_data_o
  );

  import chip_pkg::*;

  tag_payload_u clk_gen_cfg_lo;
  tag_payload_u core_cfg_lo;

  core_link_if #(.link_width_p( link_width_gp )) core_link ();

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////

  tag_master btm
    (.core_clk_i   ( core_clk_i     )
    ,.rst_n_i      ( rst_n_i        )
    ,.tag_en_i     ( tag_en_i       )
    ,.tag_data_i   ( tag_data_i     )
    ,.clk_gen_cfg_o( clk_gen_cfg_lo )
    ,.core_cfg_o   ( core_cfg_lo    )
    );

  // Off-chip clock
  clk_out_gen clk_out
    (.core_clk_i   ( core_clk_i     )
    ,.rst_n_i      ( rst_n_i        )
    ,.ext_clk_i    ( ext_clk_i      )
    ,.out_disable_i( out_disable_i  )
    ,.sel_i        ( sel_i          )
    ,.cfg_i        ( clk_gen_cfg_lo )
    ,.clk_o        ( clk_o          )
    );

  ////////////////////////////////////////
  // Link
  ////////////////////////////////////////

  link_rx #(.link_width_p  ( link_width_gp   )
           ,.link_credits_p( link_credits_gp )
           )
    rx_link
      (.core_clk_i ( core_clk_i  )
      ,.rst_n_i    ( rst_n_i     )
      ,.link_v_i   ( link_v_i    )
      ,.link_data_i( link_data_i )
      ,.link_tkn_o ( link_tkn_o  )
      ,.core_link  ( core_link   )
      );

  link_tx #(.link_width_p  ( link_width_gp   )
           ,.link_credits_p( link_credits_gp )
           )
    tx_link
      (.core_clk_i ( core_clk_i  )
      ,.rst_n_i    ( rst_n_i     )
      ,.link_tkn_i ( link_tkn_i  )
      ,.link_v_o   ( link_v_o    )
      ,.link_data_o( link_data_o )
      ,.core_link  ( core_link   )
      );

  ////////////////////////////////////////
  // Core
  ////////////////////////////////////////

  core_complex #(.link_width_p( link_width_gp )) core
    (.core_clk_i( core_clk_i  )
    ,.rst_n_i   ( rst_n_i     )
    ,.cfg_i     ( core_cfg_lo )
    ,.core_link ( core_link   )
    );

endmodule

//--- sim/link_checker.sv
`timescale 1ns/10ps

module link_checker
  #(parameter int link_credits_p = 4
   ,parameter int cnt_width_p    = $clog2(link_credits_p + 1)
   )
  (input logic                   clk_i
  ,input logic                   rst_n_i
  ,input logic [cnt_width_p-1:0] credit_i
  ,input logic                   send_i
  ,input logic                   word_in_i
  ,input logic                   full_i
  ,input logic                   out_v_i
  );

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  // Credits held in link_tx and words held in link_rx
  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_i <= cnt_width_p'(link_credits_p))
    else $error("counter above the link credit count");

  credit_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(send_i && credit_i == '0))
    else $error("counter decremented at zero");

  // A push into a full FIFO would drop a word
  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(word_in_i && full_i))
    else $error("counter incremented while already full");

  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !out_v_i)
    else $error("link output high during reset");

endmodule

bind link_tx link_checker #(.link_credits_p( link_credits_p )) tx_check
  (.clk_i    ( core_clk_i                                 )
  ,.rst_n_i  ( rst_n_i                                    )
  ,.credit_i ( credit_r                                   )
  ,.send_i   ( send                                       )
  ,.word_in_i( link_tkn_i                                 )
  ,.full_i   ( credit_r == cnt_width_lp'(link_credits_p) )
  ,.out_v_i  ( link_v_o                                   )
  );

bind link_rx link_checker #(.link_credits_p( link_credits_p )) rx_check
  (.clk_i    ( core_clk_i )
  ,.rst_n_i  ( rst_n_i    )
  ,.credit_i ( count_r    )
  ,.send_i   ( pop        )
  ,.word_in_i( link_v_i   )
  ,.full_i   ( full       )
  ,.out_v_i  ( link_tkn_o )
  );

//--- sim/tb_chip.sv
`timescale 1ns/10ps

module tb_chip;

  import chip_pkg::*;

  localparam int clk_period_lp      = 4;
  localparam int reset_cycles_lp    = 16;
  localparam int idle_words_lp      = link_credits_gp;
  localparam int random_words_lp    = 200;
  localparam int bp_words_lp        = 60;
  localparam int recheck_words_lp   = 16;
  localparam int total_words_lp     = idle_words_lp + random_words_lp + bp_words_lp
                                    + recheck_words_lp;
  localparam int watchdog_cycles_lp = 400 * total_words_lp + 2000;

  logic        core_clk;
  logic        rst_n;
  logic        tag_en;
  logic        tag_data;
  logic        ext_clk;
  logic        out_disable;
  logic [1:0]  sel;
  logic        link_v;
  logic        link_tkn;
  logic [15:0] link_data;
  logic        clk_out;
  logic        link_v_out;
  logic        link_tkn_out;
  logic [15:0] link_data_out;

  integer      seed;
  int          cycle;
  int          remote_credits;
  int          words_sent;
  int          tokens_seen;
  int          outstanding;
  int          max_outstanding;
  bit          quiet;
  bit          hold_tokens;
  bit          bp_active;
  logic [6:0]  offset;
  logic [5:0]  cur_ds;
  logic [15:0] expected_q [$];
  int          token_due_q [$];

  chip_top dut
    (.core_clk_i   ( core_clk      )
    ,.rst_n_i      ( rst_n         )
    ,.tag_en_i     ( tag_en        )
    ,.tag_data_i   ( tag_data      )
    ,.ext_clk_i    ( ext_clk       )
    ,.out_disable_i( out_disable   )
    ,.sel_i        ( sel           )
    ,.link_v_i     ( link_v        )
    ,.link_tkn_i   ( link_tkn      )
    ,.link_data_i  ( link_data     )
    ,.clk_o        ( clk_out       )
    ,.link_v_o     ( link_v_out    )
    ,.link_tkn_o   ( link_tkn_out  )
    ,.link_data_o  ( link_data_out )
    );

  initial
  begin
    core_clk = 1'b0;
    forever #(clk_period_lp / 2) core_clk = ~core_clk;
  end

  always @(posedge core_clk)
    cycle <= cycle + 1;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic int rand_range(input int n);
    return int'({$random(seed)} % n);
  endfunction

  task automatic next_cycle();
    @(posedge core_clk);
    #1;
  endtask

  ////////////////////////////////////////
  // Remote end of the link
  ////////////////////////////////////////

  task automatic check_output();
    logic [15:0] expected;
    assert (!quiet) else fail_run("link_v_o rose while the link was disabled");
    assert (expected_q.size() > 0) else fail_run("link_v_o rose with no word pending");
    expected = expected_q.pop_front();
    assert (link_data_out == expected)
      else fail_run($sformatf("[ERROR] link_data_o: got 0x%04h expected 0x%04h",
                              link_data_out, expected));
    outstanding++;
    if (outstanding > max_outstanding)
      max_outstanding = outstanding;
    assert (outstanding <= link_credits_gp)
      else fail_run("more words came out than the credits allow without tokens");
    token_due_q.push_back(cycle + rand_range(7));
  endtask

  // Outputs settle after the rising edge
  always @(negedge core_clk)
  begin
    if (rst_n)
    begin
      if (link_tkn_out)
      begin
        tokens_seen++;
        remote_credits++;
        assert (tokens_seen <= words_sent)
          else fail_run("link_tkn_o pulsed more often than words were sent");
      end
      if (link_v_out)
        check_output();
    end
  end

  // Tokens go back one per cycle unless held
  always @(posedge core_clk)
  begin
    #1;
    link_tkn = 1'b0;
    if (!hold_tokens && token_due_q.size() > 0 && token_due_q[0] <= cycle)
    begin
      void'(token_due_q.pop_front());
      outstanding--;
      link_tkn = 1'b1;
    end
  end

  task automatic send_word(input logic [15:0] data);
    logic [15:0] sum;
    while (remote_credits == 0)
    begin
      link_v = 1'b0;
      next_cycle();
    end
    sum = data + {9'd0, offset};
    link_v = 1'b1;
    link_data = data;
    remote_credits--;
    words_sent++;
    expected_q.push_back(sum);
    next_cycle();
    link_v = 1'b0;
  endtask

  task automatic send_random_word();
    logic [15:0] word;
    word = 16'($random(seed));
    send_word(word);
    if (rand_range(4) == 0)
      next_cycle();
  endtask

  // Every word has come out and every token has gone back
  task automatic drain_link();
    while (expected_q.size() != 0 || outstanding != 0)
      next_cycle();
    assert (tokens_seen == words_sent)
      else fail_run($sformatf("[ERROR] link_tkn_o pulse count: got 0x%0h expected 0x%0h",
                              tokens_seen, words_sent));
  endtask

  ////////////////////////////////////////
  // Configuration frames
  ////////////////////////////////////////

  task automatic send_frame(input logic [1:0] id, input logic [7:0] payload);
    logic [tag_frame_bits_gp-1:0] bits;
    bits = {1'b1, id, payload};
    tag_en = 1'b1;
    for (int i = tag_frame_bits_gp - 1; i >= 0; i--)
    begin
      tag_data = bits[i];
      next_cycle();
    end
    tag_en = 1'b0;
    tag_data = 1'b0;
    next_cycle();
  endtask

  // Start bit plus keep body bits, then tag_en drops
  task automatic abort_frame(input logic [1:0] id, input logic [7:0] payload,
                             input int keep);
    logic [tag_frame_bits_gp-1:0] bits;
    bits = {1'b1, id, payload};
    tag_en = 1'b1;
    for (int i = tag_frame_bits_gp - 1; i >= tag_frame_bits_gp - 1 - keep; i--)
    begin
      tag_data = bits[i];
      next_cycle();
    end
    tag_en = 1'b0;
    tag_data = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic set_core(input logic enable, input logic [6:0] off);
    send_frame(2'(tag_core_id_gp), {enable, off});
    offset = off;
  endtask

  task automatic set_divider(input logic [5:0] ds);
    send_frame(2'(tag_clk_gen_id_gp), {2'b00, ds});
    cur_ds = ds;
  endtask

  ////////////////////////////////////////
  // Clock output checks
  ////////////////////////////////////////

  task automatic measure_divider(input logic [5:0] ds);
    time t_prev;
    time t_now;
    time expected;
    expected = (ds + 1) * clk_period_lp;
    // First edges may belong to the restart
    repeat (2) @(clk_out);
    t_prev = $time;
    repeat (4)
    begin
      @(clk_out);
      t_now = $time;
      assert (t_now - t_prev == expected)
        else fail_run($sformatf("[ERROR] clk_o edge interval: got 0x%0h expected 0x%0h",
                                t_now - t_prev, expected));
      t_prev = t_now;
    end
    next_cycle();
  endtask

  task automatic check_clk_level(input int n, input bit follow);
    repeat (n)
    begin
      next_cycle();
      assert (clk_out === follow)
        else fail_run($sformatf("[ERROR] clk_o: got 0x%0h expected 0x%0h", clk_out, follow));
      #2;
      assert (clk_out === 1'b0)
        else fail_run($sformatf("[ERROR] clk_o: got 0x%0h expected 0x0", clk_out));
    end
    next_cycle();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic disabled_link_test();
    quiet = 1'b1;
    set_core(1'b0, 7'(rand_range(128)));
    repeat (idle_words_lp)
      send_random_word();
    repeat (40) next_cycle();
    assert (tokens_seen == 0) else fail_run("tokens came back while the link was disabled");
    quiet = 1'b0;
    set_core(1'b1, offset);
    drain_link();
  endtask

  task automatic random_offset_test();
    int target;
    int burst;
    target = words_sent + random_words_lp;
    while (words_sent < target)
    begin
      drain_link();
      set_core(1'b1, 7'(rand_range(128)));
      burst = 1 + rand_range(24);
      while (burst > 0 && words_sent < target)
      begin
        send_random_word();
        burst--;
      end
    end
    drain_link();
  endtask

  task automatic backpressure_test();
    int target;
    set_core(1'b1, 7'(rand_range(128)));
    target = words_sent + bp_words_lp;
    max_outstanding = 0;
    bp_active = 1'b1;
    fork
      begin
        while (words_sent < target)
          send_random_word();
        bp_active = 1'b0;
      end
      begin
        while (bp_active)
        begin
          hold_tokens = 1'b1;
          repeat (20 + rand_range(40)) @(posedge core_clk);
          hold_tokens = 1'b0;
          repeat (2 + rand_range(10)) @(posedge core_clk);
        end
      end
    join
    drain_link();
    assert (max_outstanding == link_credits_gp)
      else fail_run("back-pressure never used up the link credits");
  endtask

  task automatic clock_output_test();
    sel = 2'd1;
    for (int i = 0; i < 6; i++)
    begin
      set_divider(6'(rand_range(64)));
      measure_divider(cur_ds);
    end
    sel = 2'd3;
    check_clk_level(50, 1'b0);
    sel = 2'd0;
    check_clk_level(20, 1'b1);
    out_disable = 1'b1;
    check_clk_level(50, 1'b0);
    out_disable = 1'b0;
    sel = 2'd1;
    next_cycle();
  endtask

  // Neither stray ids nor cut frames reach a client register
  task automatic bad_frame_test();
    send_frame(2'd2, 8'(rand_range(256)));
    send_frame(2'd3, 8'(rand_range(256)));
    abort_frame(2'(tag_core_id_gp), {1'b0, ~offset}, 5);
    abort_frame(2'(tag_clk_gen_id_gp), {2'b00, ~cur_ds}, 9);
    measure_divider(cur_ds);
    repeat (recheck_words_lp)
      send_random_word();
    drain_link();
  endtask

  initial
  begin
    seed = 77;
    cycle = 0;
    remote_credits = link_credits_gp;
    words_sent = 0;
    tokens_seen = 0;
    outstanding = 0;
    max_outstanding = 0;
    quiet = 1'b0;
    hold_tokens = 1'b0;
    bp_active = 1'b0;
    offset = '0;
    cur_ds = '0;
    rst_n = 1'b0;
    tag_en = 1'b0;
    tag_data = 1'b0;
    ext_clk = 1'b0;
    out_disable = 1'b0;
    sel = 2'd0;
    link_v = 1'b0;
    link_tkn = 1'b0;
    link_data = '0;
    repeat (reset_cycles_lp) @(posedge core_clk);
    #1;
    rst_n = 1'b1;
    assert (link_v_out == 1'b0 && link_tkn_out == 1'b0)
      else fail_run("link outputs not idle after reset");
    disabled_link_test();
    random_offset_test();
    backpressure_test();
    clock_output_test();
    bad_frame_test();
    $display("TEST OK");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles_lp) @(posedge core_clk);
    fail_run("watchdog expired before the tests finished");
  end

endmodule

//--- list.f
logic/chip_pkg.sv
logic/core_link_if.sv
logic/tag_master.sv
logic/clk_out_gen.sv
logic/link_rx.sv
logic/link_tx.sv
logic/core_complex.sv
logic/chip_top.sv
sim/link_checker.sv
sim/tb_chip.sv

//--- run.sh
#!/bin/sh
# Build and run the chip testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_chip -f list.f -o tb_chip_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_chip_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
